/* Bender.yml */
package:
  name: simd_fp

export_include_dirs:
  - logic

sources:
  - files:
      - logic/simd_fp_pkg.sv
      - logic/simd_fp_if.sv
      - logic/fp_half_lo.sv
      - logic/fp_half_hi.sv
      - logic/fp_merge.sv
      - logic/simd_fp_unit.sv
  - target: test
    files:
      - test/simd_fp_checker.sv
      - test/simd_fp_tb.sv

/* logic/fp_half_hi.sv */
`include "simd_fp_defines.svh"
`default_nettype none

module fp_half_hi (
  input wire      clk,
  input wire      reset,
  issue_if.dst    iss,
  half_res_if.src res
);
  import simd_fp_pkg::*;

  logic [`SFP_LATENCY-1:0] vld_pipe;
  fp_op_e                  op_s1;
  fp_word_u                a_s1;
  fp_word_u                b_s1;
  fp_single_t              ha;
  fp_single_t              hb;
  fp_single_t              sgnj;
  fp_double_t              da;
  fp_double_t              db;
  logic                    dbl_op;
  logic [`SFP_WORD-1:0]    res_d;
  logic [`SFP_WORD-1:0]    res_q;
  fp_flags_t               flags_d;
  fp_flags_t               flags_q;
  logic                    inv_d;
  logic                    inv_q;
  logic                    wide_d;
  logic                    wide_q;

  assign ha = a_s1.s[1];
  assign hb = b_s1.s[1];
  assign da = a_s1.d;
  assign db = b_s1.d;
  assign sgnj = '{sign: hb.sign, exp: ha.exp, frac: ha.frac};

  assign dbl_op = op_s1 inside {op_cmp_d, op_max_d};

  always_ff @(posedge clk) begin
    if (reset) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[`SFP_LATENCY-2:0], iss.valid};
    end
  end

  // Operand stage, then result stage.
  always_ff @(posedge clk) begin
    if (iss.valid) begin
      op_s1 <= iss.op;
      a_s1  <= iss.a;
      b_s1  <= iss.b;
    end
    res_q   <= res_d;
    flags_q <= flags_d;
    inv_q   <= inv_d;
    wide_q  <= wide_d;
  end

  always_comb begin
    res_d   = '0;
    flags_d = '0;
    inv_d   = 1'b0;
    wide_d  = 1'b0;
    if (vld_pipe[0]) begin
      wide_d = dbl_op;
      if (dbl_op) begin
        inv_d = is_snan_d(da) || is_snan_d(db);
      end else begin
        inv_d = is_snan_s(ha) || is_snan_s(hb);
      end
      case (op_s1)
        op_min_s:  res_d[`SFP_WORD-1:`SFP_HALF] = sel_s(ha, hb, 1'b0);
        op_max_s:  res_d[`SFP_WORD-1:`SFP_HALF] = sel_s(ha, hb, 1'b1);
        op_cmp_s:  flags_d = cmp_s(ha, hb);
        op_sgnj_s: res_d[`SFP_WORD-1:`SFP_HALF] = sgnj;
        op_cmp_d:  flags_d = cmp_d(da, db);  // Result word stays zero.
        op_max_d:  res_d = sel_d(da, db, 1'b1);
        default: begin
          inv_d  = 1'b0;
          wide_d = 1'b0;
        end
      endcase
    end
  end

  assign res.valid   = vld_pipe[`SFP_LATENCY-1];
  assign res.result  = res_q;
  assign res.flags   = flags_q;
  assign res.invalid = inv_q;
  assign res.wide    = wide_q;

endmodule

`default_nettype wire

/* logic/fp_half_lo.sv */
`include "simd_fp_defines.svh"
`default_nettype none

module fp_half_lo (
  input wire      clk,
  input wire      reset,
  issue_if.dst    iss,
  half_res_if.src res
);
  import simd_fp_pkg::*;

  logic [`SFP_LATENCY-1:0] vld_pipe;
  fp_op_e                  op_s1;
  fp_word_u                a_s1;
  fp_word_u                b_s1;
  fp_single_t              la;
  fp_single_t              lb;
  fp_single_t              sgnj;
  logic                    lane_op;
  logic [`SFP_WORD-1:0]    res_d;
  logic [`SFP_WORD-1:0]    res_q;
  fp_flags_t               flags_d;
  fp_flags_t               flags_q;
  logic                    inv_d;
  logic                    inv_q;

  assign la = a_s1.s[0];
  assign lb = b_s1.s[0];
  assign sgnj = '{sign: lb.sign, exp: la.exp, frac: la.frac};

  // Double operations belong to the high half.
  assign lane_op = vld_pipe[0] && (op_s1 inside {op_min_s, op_max_s, op_cmp_s, op_sgnj_s});

  always_ff @(posedge clk) begin
    if (reset) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[`SFP_LATENCY-2:0], iss.valid};
    end
  end

  always_ff @(posedge clk) begin
    if (iss.valid) begin
      op_s1 <= iss.op;
      a_s1  <= iss.a;
      b_s1  <= iss.b;
    end
    res_q   <= res_d;
    flags_q <= flags_d;
    inv_q   <= inv_d;
  end

  always_comb begin
    res_d   = '0;
    flags_d = '0;
    inv_d   = 1'b0;
    if (lane_op) begin
      inv_d = is_snan_s(la) || is_snan_s(lb);
      case (op_s1)
        op_min_s:  res_d[`SFP_HALF-1:0] = sel_s(la, lb, 1'b0);
        op_max_s:  res_d[`SFP_HALF-1:0] = sel_s(la, lb, 1'b1);
        op_cmp_s:  flags_d = cmp_s(la, lb);
        op_sgnj_s: res_d[`SFP_HALF-1:0] = sgnj;
        default:   res_d = '0;
      endcase
    end
  end

  assign res.valid   = vld_pipe[`SFP_LATENCY-1];
  assign res.result  = res_q;
  assign res.flags   = flags_q;
  assign res.invalid = inv_q;
  assign res.wide    = 1'b0;  // Lane 0 never holds a double.

endmodule

`default_nettype wire

/* logic/fp_merge.sv */
`include "simd_fp_defines.svh"
`default_nettype none

module fp_merge (
  input wire                       clk,
  input wire                       reset,
  half_res_if.dst                  lo,
  half_res_if.dst                  hi,
  input wire                       clear_flags,
  output logic                     out_valid,
  output logic [`SFP_WORD-1:0]     result,
  output simd_fp_pkg::fp_flags_t   flags_lo,
  output simd_fp_pkg::fp_flags_t   flags_hi,
  output logic                     out_invalid,
  output logic                     invalid_sticky
);

  // Idle halves drive zeros, so a plain OR joins them.
  assign out_valid   = lo.valid | hi.valid;
  assign result      = lo.result | hi.result;
  assign out_invalid = lo.invalid | hi.invalid;

  // Double flags come out on lane 0.
  always_comb begin
    if (hi.wide) begin
      flags_lo = hi.flags;
      flags_hi = '0;
    end else begin
      flags_lo = lo.flags;
      flags_hi = hi.flags;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      invalid_sticky <= 1'b0;
    end else if (clear_flags) begin
      invalid_sticky <= 1'b0;  // Clear wins over a new invalid.
    end else if (out_valid && out_invalid) begin
      invalid_sticky <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/simd_fp_defines.svh */
`ifndef SIMD_FP_DEFINES_SVH
`define SIMD_FP_DEFINES_SVH

`default_nettype none

// Operand word and lane widths.
`define SFP_WORD 64
`define SFP_HALF 32

`define SFP_LATENCY 2  // Issue to result, in cycles.

// Canonical quiet NaNs.
`define SFP_QNAN_S 32'h7fc0_0000
`define SFP_QNAN_D 64'h7ff8_0000_0000_0000

`default_nettype wire

`endif

/* logic/simd_fp_if.sv */
`include "simd_fp_defines.svh"
`default_nettype none

interface issue_if;
  import simd_fp_pkg::*;

  logic     valid;
  fp_op_e   op;
  fp_word_u a;
  fp_word_u b;

  modport src (
    output valid,
    output op,
    output a,
    output b
  );

  modport dst (
    input valid,
    input op,
    input a,
    input b
  );
endinterface

interface half_res_if;
  import simd_fp_pkg::*;

  logic                 valid;
  logic [`SFP_WORD-1:0] result;  // Lane bits only, or the whole word when wide.
  fp_flags_t            flags;
  logic                 invalid;
  logic                 wide;

  modport src (
    output valid,
    output result,
    output flags,
    output invalid,
    output wide
  );

  modport dst (
    input valid,
    input result,
    input flags,
    input invalid,
    input wide
  );
endinterface

`default_nettype wire

/* logic/simd_fp_pkg.sv */
`include "simd_fp_defines.svh"
`default_nettype none

package simd_fp_pkg;

  typedef enum logic [2:0] {
    op_min_s,
    op_max_s,
    op_cmp_s,
    op_sgnj_s,
    op_cmp_d,
    op_max_d
  } fp_op_e;

  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] frac;
  } fp_single_t;

  typedef struct packed {
    logic        sign;
    logic [10:0] exp;
    logic [51:0] frac;
  } fp_double_t;

  // One operand word, seen as a double or as two single lanes.
  typedef union packed {
    fp_double_t       d;
    fp_single_t [1:0] s;  // s[0] is lane 0, the low half.
  } fp_word_u;

  typedef struct packed {
    logic lt;
    logic eq;
    logic gt;
    logic unord;
  } fp_flags_t;

  function automatic logic is_nan_s(fp_single_t x);
    return (x.exp == '1) && (x.frac != '0);
  endfunction

  function automatic logic is_nan_d(fp_double_t x);
    return (x.exp == '1) && (x.frac != '0);
  endfunction

  function automatic logic is_snan_s(fp_single_t x);
    return is_nan_s(x) && !x.frac[22];  // Quiet bit clear.
  endfunction

  function automatic logic is_snan_d(fp_double_t x);
    return is_nan_d(x) && !x.frac[51];
  endfunction

  // Sign-magnitude order on non-NaN values; -0 sorts below +0.
  function automatic logic lt_s(fp_single_t x, fp_single_t y);
    if (x.sign != y.sign) return x.sign;
    if (x.sign) return {x.exp, x.frac} > {y.exp, y.frac};
    return {x.exp, x.frac} < {y.exp, y.frac};
  endfunction

  function automatic logic lt_d(fp_double_t x, fp_double_t y);
    if (x.sign != y.sign) return x.sign;
    if (x.sign) return {x.exp, x.frac} > {y.exp, y.frac};
    return {x.exp, x.frac} < {y.exp, y.frac};
  endfunction

  function automatic fp_flags_t cmp_s(fp_single_t x, fp_single_t y);
    fp_flags_t f;
    f = '0;
    if (is_nan_s(x) || is_nan_s(y)) begin
      f.unord = 1'b1;
    end else if ((x == y) || ({x.exp, x.frac, y.exp, y.frac} == '0)) begin
      f.eq = 1'b1;  // Covers +0 == -0.
    end else if (lt_s(x, y)) begin
      f.lt = 1'b1;
    end else begin
      f.gt = 1'b1;
    end
    return f;
  endfunction

  function automatic fp_flags_t cmp_d(fp_double_t x, fp_double_t y);
    fp_flags_t f;
    f = '0;
    if (is_nan_d(x) || is_nan_d(y)) begin
      f.unord = 1'b1;
    end else if ((x == y) || ({x.exp, x.frac, y.exp, y.frac} == '0)) begin
      f.eq = 1'b1;
    end else if (lt_d(x, y)) begin
      f.lt = 1'b1;
    end else begin
      f.gt = 1'b1;
    end
    return f;
  endfunction

  function automatic fp_single_t sel_s(fp_single_t x, fp_single_t y, logic take_max);
    if (is_nan_s(x) && is_nan_s(y)) return fp_single_t'(`SFP_QNAN_S);
    if (is_nan_s(x)) return y;
    if (is_nan_s(y)) return x;
    return (lt_s(x, y) ^ take_max) ? x : y;
  endfunction

  function automatic fp_double_t sel_d(fp_double_t x, fp_double_t y, logic take_max);
    if (is_nan_d(x) && is_nan_d(y)) return fp_double_t'(`SFP_QNAN_D);
    if (is_nan_d(x)) return y;
    if (is_nan_d(y)) return x;
    return (lt_d(x, y) ^ take_max) ? x : y;
  endfunction

endpackage

`default_nettype wire

/* logic/simd_fp_unit.sv */
`include "simd_fp_defines.svh"
`default_nettype none

module simd_fp_unit (
  input wire                          clk,
  input wire                          reset,
  input wire                          in_valid,
  input wire simd_fp_pkg::fp_op_e     op,
  input wire [`SFP_WORD-1:0]          a,
  input wire [`SFP_WORD-1:0]          b,
  input wire                          clear_flags,
  output logic                        out_valid,
  output logic [`SFP_WORD-1:0]        result,
  output simd_fp_pkg::fp_flags_t      flags_lo,
  output simd_fp_pkg::fp_flags_t      flags_hi,
  output logic                        out_invalid,
  output logic                        invalid_sticky
);

  issue_if    iss ();
  half_res_if lo_res ();
  half_res_if hi_res ();

  // Both halves see the same issue bus.
  assign iss.valid = in_valid;
  assign iss.op    = op;
  assign iss.a     = a;
  assign iss.b     = b;

  fp_half_lo u_half_lo (
    .clk   (clk),
    .reset (reset),
    .iss   (iss.dst),
    .res   (lo_res.src)
  );

  fp_half_hi u_half_hi (
    .clk   (clk),
    .reset (reset),
    .iss   (iss.dst),
    .res   (hi_res.src)
  );

  fp_merge u_merge (
    .clk            (clk),
    .reset          (reset),
    .lo             (lo_res.dst),
    .hi             (hi_res.dst),
    .clear_flags    (clear_flags),
    .out_valid      (out_valid),
    .result         (result),
    .flags_lo       (flags_lo),
    .flags_hi       (flags_hi),
    .out_invalid    (out_invalid),
    .invalid_sticky (invalid_sticky)
  );

endmodule

`default_nettype wire

/* sources.f */
+incdir+logic
logic/simd_fp_pkg.sv
logic/simd_fp_if.sv
logic/fp_half_lo.sv
logic/fp_half_hi.sv
logic/fp_merge.sv
logic/simd_fp_unit.sv
test/simd_fp_checker.sv
test/simd_fp_tb.sv

/* test/simd_fp_checker.sv */
`include "simd_fp_defines.svh"
`default_nettype none

module simd_fp_checker (
  input wire clk,
  input wire reset,
  input wire in_valid,
  input wire clear_flags,
  input wire out_valid,
  input wire out_invalid,
  input wire invalid_sticky
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  a_latency: assert property (@(posedge clk) disable iff (reset)
    out_valid == $past(in_valid, `SFP_LATENCY))
    else begin
      fail_count++;
      $error("out_valid does not follow in_valid by the latency");
    end

  a_reset: assert property (@(posedge clk) reset |=> (!out_valid && !invalid_sticky))
    else begin
      fail_count++;
      $error("outputs not cleared by reset");
    end

  a_clear: assert property (@(posedge clk) disable iff (reset) clear_flags |=> !invalid_sticky)
    else begin
      fail_count++;
      $error("sticky invalid survived a clear");
    end

  a_set: assert property (@(posedge clk) disable iff (reset)
    (out_valid && out_invalid && !clear_flags) |=> invalid_sticky)
    else begin
      fail_count++;
      $error("sticky invalid not set by an invalid result");
    end

  a_hold: assert property (@(posedge clk) disable iff (reset)
    (invalid_sticky && !clear_flags) |=> invalid_sticky)
    else begin
      fail_count++;
      $error("sticky invalid dropped without a clear");
    end

  a_idle: assert property (@(posedge clk) disable iff (reset) !out_valid |-> !out_invalid)
    else begin
      fail_count++;
      $error("out_invalid high without a result");
    end

endmodule

bind simd_fp_unit simd_fp_checker u_checker (
  .clk            (clk),
  .reset          (reset),
  .in_valid       (in_valid),
  .clear_flags    (clear_flags),
  .out_valid      (out_valid),
  .out_invalid    (out_invalid),
  .invalid_sticky (invalid_sticky)
);

`default_nettype wire

/* test/simd_fp_tb.sv */
`include "simd_fp_defines.svh"
`default_nettype none

module simd_fp_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import simd_fp_pkg::*;

  localparam int N_OPS = 400;
  localparam int TIMEOUT_CYCLES = 2 * N_OPS + 50;  // At most one idle cycle per op.

  typedef struct packed {
    logic [31:0] due;
    logic [63:0] result;
    logic [3:0]  flo;
    logic [3:0]  fhi;
    logic        inv;
  } expect_t;

  logic        clk;
  logic        reset;
  logic        in_valid;
  logic        clear_flags;
  fp_op_e      op;
  logic [63:0] a;
  logic [63:0] b;
  logic        out_valid;
  logic [63:0] result;
  fp_flags_t   flags_lo;
  fp_flags_t   flags_hi;
  logic        out_invalid;
  logic        invalid_sticky;
  expect_t     exp_q [$];
  logic [15:0] lfsr_state;
  logic        sticky_model;
  int          cycle = 0;
  int          errors = 0;
  int          results = 0;

  simd_fp_unit DUT (
    .clk            (clk),
    .reset          (reset),
    .in_valid       (in_valid),
    .op             (op),
    .a              (a),
    .b              (b),
    .clear_flags    (clear_flags),
    .out_valid      (out_valid),
    .result         (result),
    .flags_lo       (flags_lo),
    .flags_hi       (flags_hi),
    .out_invalid    (out_invalid),
    .invalid_sticky (invalid_sticky)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr_state[0];
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 16'hb400 : lfsr_state >> 1;
    end
  endtask

  // Special values or a random word, in the double or the single layout.
  task automatic pick_value(input logic dbl, output logic [63:0] v);
    logic [63:0] k;
    logic [63:0] r;
    take_bits(3, k);
    take_bits(64, r);
    case (k)
      0: v = dbl ? {r[63], 63'h0} : {32'h0, r[31], 31'h0};
      1: v = dbl ? {r[63], 11'h7ff, 52'h0} : {32'h0, r[31], 8'hff, 23'h0};
      2: v = dbl ? {r[63], 11'h7ff, 1'b1, r[50:0]} : {32'h0, r[31], 8'hff, 1'b1, r[21:0]};
      3: v = dbl ? {r[63], 11'h7ff, 1'b0, r[50:1], 1'b1} :
                   {32'h0, r[31], 8'hff, 1'b0, r[21:1], 1'b1};  // Signaling NaN.
      default: v = dbl ? r : {32'h0, r[31:0]};
    endcase
  endtask

  task automatic pick_operand(input logic dbl, output logic [63:0] v);
    logic [63:0] lo;
    logic [63:0] hi;
    pick_value(dbl, lo);
    pick_value(dbl, hi);
    v = dbl ? lo : {hi[31:0], lo[31:0]};
  endtask

  function automatic logic nan_of(logic [63:0] x, logic dbl);
    return dbl ? (x[62:52] == 11'h7ff && x[51:0] != 0) : (x[30:23] == 8'hff && x[22:0] != 0);
  endfunction

  function automatic logic snan_of(logic [63:0] x, logic dbl);
    return nan_of(x, dbl) && !(dbl ? x[51] : x[22]);
  endfunction

  // Unsigned key with the same order as the values; -0 sits just below +0.
  function automatic logic [63:0] order_key(logic [63:0] x, logic dbl);
    if (dbl) return x[63] ? ~x : {1'b1, x[62:0]};
    return {32'h0, x[31] ? ~x[31:0] : {1'b1, x[30:0]}};
  endfunction

  function automatic logic [3:0] cmp_ref(logic [63:0] x, logic [63:0] y, logic dbl);
    logic zeros;
    zeros = dbl ? (x[62:0] == 0 && y[62:0] == 0) : (x[30:0] == 0 && y[30:0] == 0);
    if (nan_of(x, dbl) || nan_of(y, dbl)) return 4'b0001;
    if (zeros || order_key(x, dbl) == order_key(y, dbl)) return 4'b0100;
    return (order_key(x, dbl) < order_key(y, dbl)) ? 4'b1000 : 4'b0010;
  endfunction

  function automatic logic [63:0] sel_ref(logic [63:0] x, logic [63:0] y, logic dbl,
                                          logic take_max);
    if (nan_of(x, dbl) && nan_of(y, dbl)) return dbl ? `SFP_QNAN_D : {32'h0, `SFP_QNAN_S};
    if (nan_of(x, dbl)) return y;
    if (nan_of(y, dbl)) return x;
    return ((order_key(x, dbl) > order_key(y, dbl)) == take_max) ? x : y;
  endfunction

  function automatic expect_t ref_model(fp_op_e o, logic [63:0] x, logic [63:0] y);
    expect_t     e;
    logic [63:0] la;
    logic [63:0] lb;
    logic [63:0] lane;
    logic [3:0]  f;
    e = '0;
    if (o == op_cmp_d || o == op_max_d) begin
      e.inv = snan_of(x, 1'b1) || snan_of(y, 1'b1);
      if (o == op_cmp_d) e.flo = cmp_ref(x, y, 1'b1);
      else e.result = sel_ref(x, y, 1'b1, 1'b1);
      return e;
    end
    for (int l = 0; l < 2; l++) begin
      la = {32'h0, x[32*l +: 32]};
      lb = {32'h0, y[32*l +: 32]};
      lane = '0;
      f = '0;
      case (o)
        op_min_s:  lane = sel_ref(la, lb, 1'b0, 1'b0);
        op_max_s:  lane = sel_ref(la, lb, 1'b0, 1'b1);
        op_cmp_s:  f = cmp_ref(la, lb, 1'b0);
        default:   lane = {32'h0, lb[31], la[30:0]};  // Sign injection.
      endcase
      e.result[32*l +: 32] = lane[31:0];
      if (l == 0) e.flo = f;
      else e.fhi = f;
      e.inv = e.inv || snan_of(la, 1'b0) || snan_of(lb, 1'b0);
    end
    return e;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] want);
    assert (got === want) else begin
      errors++;
      $display("Fail %0t %s: got %h, expected %h", $time, name, got, want);
    end
  endtask

  task automatic drive_clear();
    logic [63:0] k;
    take_bits(3, k);
    clear_flags = (k == 0);
  endtask

  initial begin : drive_stimulus
    logic [63:0] k;
    logic [63:0] av;
    logic [63:0] bv;
    fp_op_e      next_op;
    expect_t     e;
    lfsr_state = 16'd11320;
    reset = 1'b1;
    in_valid = 1'b0;
    op = op_min_s;
    a = '0;
    b = '0;
    clear_flags = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < N_OPS; i++) begin
      take_bits(2, k);
      if (k == 0) begin
        @(negedge clk);
        in_valid = 1'b0;
        drive_clear();
      end
      @(negedge clk);
      take_bits(3, k);
      next_op = fp_op_e'(k % 6);
      pick_operand(next_op inside {op_cmp_d, op_max_d}, av);
      pick_operand(next_op inside {op_cmp_d, op_max_d}, bv);
      take_bits(2, k);
      if (k == 0) bv = av;  // Equal pair.
      in_valid = 1'b1;
      op = next_op;
      a = av;
      b = bv;
      drive_clear();
      e = ref_model(next_op, av, bv);
      e.due = cycle + `SFP_LATENCY;
      exp_q.push_back(e);
    end
    @(negedge clk);
    in_valid = 1'b0;
    clear_flags = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);
    $display("Checks done: %0d results, %0d errors, %0d assertion failures",
             results, errors, DUT.u_checker.fail_count);
    if (errors == 0 && DUT.u_checker.fail_count == 0) $display("TEST PASSED");
    else $display("TEST FAILED");
    $finish;
  end

  // Outputs are read at the rising edge, before the DUT registers update.
  always @(posedge clk) begin : compare_results
    expect_t e;
    logic    exp_inv;
    exp_inv = 1'b0;
    if (reset) begin
      sticky_model = 1'b0;
    end else begin
      check_value("invalid_sticky", invalid_sticky, sticky_model);
      if (out_valid === 1'b1) begin
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("out_valid high at cycle %0d with no operation in flight", cycle);
        end
        if (exp_q.size() != 0) begin
          e = exp_q.pop_front();
          results++;
          assert (e.due == cycle) else begin
            errors++;
            $display("Result due at cycle %0d arrived at cycle %0d", e.due, cycle);
          end
          check_value("result", result, e.result);
          check_value("flags_lo", flags_lo, e.flo);
          check_value("flags_hi", flags_hi, e.fhi);
          check_value("out_invalid", out_invalid, e.inv);
          exp_inv = e.inv;
        end
      end else begin
        assert (out_valid === 1'b0) else begin
          errors++;
          $display("out_valid is unknown at cycle %0d", cycle);
        end
        assert (!(exp_q.size() != 0 && exp_q[0].due == cycle)) else begin
          errors++;
          $display("No result at cycle %0d for an operation that was due", cycle);
        end
      end
      sticky_model = clear_flags ? 1'b0 : (exp_inv ? 1'b1 : sticky_model);
    end
    cycle = cycle + 1;
  end

  initial begin : watchdog
    wait (cycle >= TIMEOUT_CYCLES);
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Checks done: %0d results, %0d errors, %0d assertion failures",
             results, errors, DUT.u_checker.fail_count);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
